// File: sources.f
video_pkg.sv
game_pkg.sv
vga_timing.sv
game_ctrl.sv
ball_sprite_rom.sv
score_text.sv
video_display.sv
video_overlay_top.sv
tb_video_overlay.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_video_overlay
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_video_overlay.sv
module tb_video_overlay;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int LINE_CLKS  = 800;
    localparam int FRAME_CLKS = 800 * 525;
    localparam int TEXT_X     = 500;
    localparam int TEXT_Y     = 40;

    localparam int CAM_NORMAL = 0;  // blue on even x, dark grey on odd x
    localparam int CAM_BRIGHT = 1;  // bright green from x 320 on
    localparam int CAM_DARK   = 2;  // all black

    // reference glyphs of the two digits shown
    localparam logic [7:0] GLYPH_ZERO [8] = '{8'h3C, 8'h66, 8'h6E, 8'h76,
                                              8'h66, 8'h66, 8'h3C, 8'h00};
    localparam logic [7:0] GLYPH_ONE  [8] = '{8'h18, 8'h38, 8'h18, 8'h18,
                                              8'h18, 8'h18, 8'h7E, 8'h00};

    logic               clk;
    logic               rst_n;
    logic               cyc;
    logic               stb;
    logic               we;
    game_pkg::wb_addr_t adr;
    game_pkg::wb_data_t dat_w;
    game_pkg::wb_data_t dat_r;
    logic               ack;
    video_pkg::pixel_t  camera_pixel = '0;
    video_pkg::coord_t  x_pixel;
    video_pkg::coord_t  y_pixel;
    video_pkg::colour_t red;
    video_pkg::colour_t green;
    video_pkg::colour_t blue;
    logic               hsync_out;
    logic               vsync_out;

    int                 errors;
    int                 checks;
    int                 cam_mode;
    video_pkg::coord_t  shown_x;  // what the current frame displays
    video_pkg::coord_t  shown_y;
    game_pkg::score_t   shown_score;

    video_overlay_top #(
        .TEXT_X (TEXT_X),
        .TEXT_Y (TEXT_Y)
    ) video_overlay_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .cyc          (cyc),
        .stb          (stb),
        .we           (we),
        .adr          (adr),
        .dat_w        (dat_w),
        .dat_r        (dat_r),
        .ack          (ack),
        .camera_pixel (camera_pixel),
        .x_pixel      (x_pixel),
        .y_pixel      (y_pixel),
        .red          (red),
        .green        (green),
        .blue         (blue),
        .hsync_out    (hsync_out),
        .vsync_out    (vsync_out)
    );

    always #5 clk = ~clk;

    function automatic video_pkg::pixel_t camera_value(video_pkg::coord_t x);
        if (cam_mode == CAM_DARK)
            return 16'h0000;
        if (cam_mode == CAM_BRIGHT && x >= 10'd320)
            return 16'h07E0;  // green channel 15
        return x[0] ? 16'h2104 : 16'h001F;
    endfunction

    // camera source answers one clock after the scan coordinate
    always @(posedge clk) camera_pixel <= camera_value(x_pixel);

    function automatic logic glyph_bit(int digit, int row, int col);
        return (digit == 1) ? GLYPH_ONE[row][7 - col] : GLYPH_ZERO[row][7 - col];
    endfunction

    function automatic video_pkg::pixel_t expected_pixel(int x, int y);
        int dx;
        int dy;
        int col;
        int digit;
        dx = x - int'(shown_x);
        dy = y - int'(shown_y);
        if (dx >= 0 && dx < 20 && dy >= 0 && dy < 20 &&
            (dx - 10) * (dx - 10) + (dy - 10) * (dy - 10) < 100)
            return video_pkg::SPRITE_COLOUR;
        if (x >= TEXT_X && x < TEXT_X + 32 && y >= TEXT_Y && y < TEXT_Y + 16) begin
            col   = (x - TEXT_X) / 2;
            digit = (col < 8) ? int'(shown_score) / 10 : int'(shown_score) % 10;
            return glyph_bit(digit, (y - TEXT_Y) / 2, col % 8) ? 16'hFFFF : 16'h0000;
        end
        return camera_value(video_pkg::coord_t'(x));
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $finish;
    endtask

    task automatic step_or_abort(inout int n, input int limit, input string what);
        n++;
        if (n > limit)
            abort_run(what);
        else
            @(negedge clk);
    endtask

    task automatic check_colour(input video_pkg::colour_t r, input video_pkg::colour_t g,
                                input video_pkg::colour_t b, input video_pkg::colour_t er,
                                input video_pkg::colour_t eg, input video_pkg::colour_t eb,
                                input string what);
        checks++;
        if (r !== er || g !== eg || b !== eb) begin
            errors++;
            $display("ERR %0t: %s rgb %0d/%0d/%0d, expected %0d/%0d/%0d",
                     $time, what, r, g, b, er, eg, eb);
        end
    endtask

    task automatic check_data(input game_pkg::wb_data_t got, input game_pkg::wb_data_t exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s read 0x%04h, expected 0x%04h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("ERR %0t: %s is %0d clocks, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic wb_cycle(input logic write, input game_pkg::wb_addr_t a,
                            input game_pkg::wb_data_t d, output game_pkg::wb_data_t q);
        int n;
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= write;
        adr   <= a;
        dat_w <= d;
        n = 0;
        @(negedge clk);
        while (!ack)
            step_or_abort(n, 16, "no ack from the Wishbone slave");
        check_count(n, 1, "ack latency");
        q = dat_r;
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic wb_write(input game_pkg::wb_addr_t a, input game_pkg::wb_data_t d);
        game_pkg::wb_data_t unused;
        wb_cycle(1'b1, a, d, unused);
    endtask

    task automatic wb_read(input game_pkg::wb_addr_t a, output game_pkg::wb_data_t q);
        wb_cycle(1'b0, a, '0, q);
    endtask

    task automatic wait_coord(input int x, input int y);
        int n;
        n = 0;
        @(negedge clk);
        while (x_pixel != video_pkg::coord_t'(x) || y_pixel != video_pkg::coord_t'(y))
            step_or_abort(n, 2 * FRAME_CLKS, $sformatf("scan never reached (%0d,%0d)", x, y));
    endtask

    // outputs trail the counter by two clocks
    task automatic check_run(input int x0, input int y0, input int len);
        video_pkg::pixel_t p;
        wait_coord(x0, y0);
        repeat (2) @(negedge clk);
        for (int k = 0; k < len; k++) begin
            p = expected_pixel(x0 + k, y0);
            check_colour(red, green, blue, p[15:12], p[10:7], p[4:1],
                         $sformatf("pixel (%0d,%0d)", x0 + k, y0));
            @(negedge clk);
        end
    endtask

    task automatic place_ball(input int x, input int y, input int s);
        wb_write(game_pkg::REG_BALL_X, game_pkg::wb_data_t'(x));
        wb_write(game_pkg::REG_BALL_Y, game_pkg::wb_data_t'(y));
        wb_write(game_pkg::REG_SCORE, game_pkg::wb_data_t'(s));
        wait_coord(0, 0);  // shadow copy loads here
        shown_x     = video_pkg::coord_t'(x);
        shown_y     = video_pkg::coord_t'(y);
        shown_score = game_pkg::score_t'(s);
    endtask

    task automatic test_registers();
        game_pkg::wb_data_t q;
        game_pkg::wb_data_t value;
        wb_read(game_pkg::REG_BALL_X, q);
        check_data(q, 16'h0000, "ball_x after reset");
        for (int i = 0; i < 4; i++) begin
            value = game_pkg::wb_data_t'($urandom_range(639, 0));
            wb_write(game_pkg::REG_BALL_X, value);
            wb_read(game_pkg::REG_BALL_X, q);
            check_data(q, value, "ball_x readback");
            value = game_pkg::wb_data_t'($urandom_range(479, 0));
            wb_write(game_pkg::REG_BALL_Y, value);
            wb_read(game_pkg::REG_BALL_Y, q);
            check_data(q, value, "ball_y readback");
            value = game_pkg::wb_data_t'($urandom_range(99, 0));
            wb_write(game_pkg::REG_SCORE, value);
            wb_read(game_pkg::REG_SCORE, q);
            check_data(q, value, "score readback");
            value = game_pkg::wb_data_t'($urandom_range(65535, 100));
            wb_write(game_pkg::REG_SCORE, value);
            wb_read(game_pkg::REG_SCORE, q);
            check_data(q, 16'd99, "score capped at 99");
        end
    endtask

    task automatic test_sync_timing();
        int n;
        int low;
        int line;
        n = 0;
        @(negedge clk);
        while (hsync_out !== 1'b1)
            step_or_abort(n, LINE_CLKS, "hsync never went high");
        while (hsync_out !== 1'b0)
            step_or_abort(n, 2 * LINE_CLKS, "hsync never went low");
        low = 0;
        while (hsync_out === 1'b0)
            step_or_abort(low, LINE_CLKS, "hsync stuck low");
        line = low;
        while (hsync_out === 1'b1)
            step_or_abort(line, 2 * LINE_CLKS, "hsync stuck high");
        check_count(low, 96, "hsync low width");
        check_count(line, LINE_CLKS, "line length");
        n = 0;
        while (vsync_out !== 1'b1)
            step_or_abort(n, FRAME_CLKS, "vsync never went high");
        while (vsync_out !== 1'b0)
            step_or_abort(n, 2 * FRAME_CLKS, "vsync never went low");
        low = 0;
        while (vsync_out === 1'b0)
            step_or_abort(low, FRAME_CLKS, "vsync stuck low");
        check_count(low, 2 * LINE_CLKS, "vsync low width");
    endtask

    task automatic test_ball();
        int bx;
        int by;
        bx = $urandom_range(619, 0);
        by = $urandom_range(460, 100);  // clear of the score text
        place_ball(bx, by, 5);
        for (int dy = 0; dy < 20; dy++)
            check_run(bx, by + dy, 20);
    endtask

    task automatic test_frame_sync();
        int n;
        place_ball(100, 60, 5);
        wait_coord(0, 150);
        wb_write(game_pkg::REG_BALL_X, 16'd300);
        wb_write(game_pkg::REG_BALL_Y, 16'd300);
        check_run(300, 310, 20);  // old position still on screen
        n = 0;
        @(negedge clk);
        while (vsync_out !== 1'b0)
            step_or_abort(n, 2 * FRAME_CLKS, "vsync never went low");
        shown_x = 10'd300;
        shown_y = 10'd300;
        check_run(300, 310, 20);
    endtask

    task automatic test_score_text();
        place_ball(100, 300, 10);
        check_run(TEXT_X - 2, TEXT_Y, 36);       // glyph row 0
        check_run(TEXT_X - 2, TEXT_Y + 12, 36);  // row 6
        check_run(TEXT_X - 2, TEXT_Y + 13, 36);
        check_run(TEXT_X - 2, TEXT_Y + 14, 36);  // row 7 is blank
    endtask

    task automatic test_hit();
        game_pkg::wb_data_t q;
        wb_read(game_pkg::REG_STATUS, q);
        check_bit(q[0], 1'b0, "hit flag before bright camera");
        cam_mode = CAM_BRIGHT;
        place_ball(400, 200, 10);
        wait_coord(0, 0);  // one whole frame over bright pixels
        cam_mode = CAM_NORMAL;
        wb_read(game_pkg::REG_STATUS, q);
        check_bit(q[0], 1'b1, "hit flag after bright frame");
        wb_read(game_pkg::REG_STATUS, q);
        check_bit(q[0], 1'b0, "hit flag cleared by read");
        cam_mode = CAM_DARK;
        place_ball(200, 250, 10);
        wait_coord(0, 0);
        wb_read(game_pkg::REG_STATUS, q);
        check_bit(q[0], 1'b0, "hit flag over dark camera");
        cam_mode = CAM_BRIGHT;  // bright pixels only right of the ball
        wait_coord(0, 0);
        cam_mode = CAM_NORMAL;
        wb_read(game_pkg::REG_STATUS, q);
        check_bit(q[0], 1'b0, "hit flag with bright pixels outside the ball");
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        cyc         = 1'b0;
        stb         = 1'b0;
        we          = 1'b0;
        adr         = '0;
        dat_w       = '0;
        errors      = 0;
        checks      = 0;
        cam_mode    = CAM_NORMAL;
        shown_x     = '0;
        shown_y     = '0;
        shown_score = '0;
        void'($urandom(73518));
        repeat (15) @(posedge clk);
        @(negedge clk);
        check_bit(ack, 1'b0, "ack in reset");
        check_bit(hsync_out, 1'b1, "hsync_out in reset");
        check_bit(vsync_out, 1'b1, "vsync_out in reset");
        check_colour(red, green, blue, 4'd0, 4'd0, 4'd0, "rgb in reset");
        @(posedge clk);
        rst_n <= 1'b1;
        test_registers();
        test_sync_timing();
        test_ball();
        test_frame_sync();
        test_score_text();
        test_hit();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: video_overlay_top.sv
module video_overlay_top #(
    parameter int H_ACTIVE = video_pkg::H_ACTIVE,
    parameter int H_FRONT  = video_pkg::H_FRONT,
    parameter int H_SYNC   = video_pkg::H_SYNC,
    parameter int H_BACK   = video_pkg::H_BACK,
    parameter int V_ACTIVE = video_pkg::V_ACTIVE,
    parameter int V_FRONT  = video_pkg::V_FRONT,
    parameter int V_SYNC   = video_pkg::V_SYNC,
    parameter int V_BACK   = video_pkg::V_BACK,
    parameter int TEXT_X   = 500,
    parameter int TEXT_Y   = 40,
    parameter logic [3:0] HIT_LUMA = game_pkg::HIT_LUMA
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cyc,
    input  logic                stb,
    input  logic                we,
    input  game_pkg::wb_addr_t  adr,
    input  game_pkg::wb_data_t  dat_w,
    output game_pkg::wb_data_t  dat_r,
    output logic                ack,
    input  video_pkg::pixel_t   camera_pixel,  // arrives one clock after x/y
    output video_pkg::coord_t   x_pixel,
    output video_pkg::coord_t   y_pixel,
    output video_pkg::colour_t  red,
    output video_pkg::colour_t  green,
    output video_pkg::colour_t  blue,
    output logic                hsync_out,
    output logic                vsync_out
);

    logic              active;
    logic              hsync;
    logic              vsync;
    logic              frame_start;
    video_pkg::coord_t ball_x;
    video_pkg::coord_t ball_y;
    game_pkg::score_t  score;
    video_pkg::pixel_t rom_pixel;
    logic              hit_area;
    video_pkg::pixel_t text_pixel;
    logic              text_area;

    vga_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) vga_timing_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .x_pixel     (x_pixel),
        .y_pixel     (y_pixel),
        .active      (active),
        .hsync       (hsync),
        .vsync       (vsync),
        .frame_start (frame_start)
    );

    game_ctrl #(
        .HIT_LUMA (HIT_LUMA)
    ) game_ctrl_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .cyc          (cyc),
        .stb          (stb),
        .we           (we),
        .adr          (adr),
        .dat_w        (dat_w),
        .dat_r        (dat_r),
        .ack          (ack),
        .frame_start  (frame_start),
        .active       (active),
        .hit_area     (hit_area),
        .camera_pixel (camera_pixel),
        .ball_x       (ball_x),
        .ball_y       (ball_y),
        .score        (score)
    );

    ball_sprite_rom ball_sprite_rom_inst (
        .clk       (clk),
        .ball_x    (ball_x),
        .ball_y    (ball_y),
        .x_pixel   (x_pixel),
        .y_pixel   (y_pixel),
        .rom_pixel (rom_pixel),
        .hit_area  (hit_area)
    );

    score_text #(
        .TEXT_X (TEXT_X),
        .TEXT_Y (TEXT_Y)
    ) score_text_inst (
        .clk        (clk),
        .score      (score),
        .x_pixel    (x_pixel),
        .y_pixel    (y_pixel),
        .text_pixel (text_pixel),
        .text_area  (text_area)
    );

    video_display video_display_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .camera_pixel (camera_pixel),
        .rom_pixel    (rom_pixel),
        .hit_area     (hit_area),
        .text_pixel   (text_pixel),
        .text_area    (text_area),
        .active       (active),
        .hsync        (hsync),
        .vsync        (vsync),
        .red          (red),
        .green        (green),
        .blue         (blue),
        .hsync_out    (hsync_out),
        .vsync_out    (vsync_out)
    );

endmodule

// File: video_display.sv
module video_display (
    input  logic                clk,
    input  logic                rst_n,
    input  video_pkg::pixel_t   camera_pixel,
    input  video_pkg::pixel_t   rom_pixel,
    input  logic                hit_area,
    input  video_pkg::pixel_t   text_pixel,
    input  logic                text_area,
    input  logic                active,
    input  logic                hsync,
    input  logic                vsync,
    output video_pkg::colour_t  red,
    output video_pkg::colour_t  green,
    output video_pkg::colour_t  blue,
    output logic                hsync_out,
    output logic                vsync_out
);

    logic              active_d;
    logic              hsync_d;
    logic              vsync_d;
    video_pkg::pixel_t display_pixel;

    // sprite first, then score, then the camera picture
    always_comb begin
        if (!active_d)
            display_pixel = '0;
        else if (hit_area && rom_pixel != '0)
            display_pixel = rom_pixel;
        else if (text_area)
            display_pixel = text_pixel;
        else
            display_pixel = camera_pixel;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active_d  <= 1'b0;
            hsync_d   <= 1'b1;
            vsync_d   <= 1'b1;
            hsync_out <= 1'b1;
            vsync_out <= 1'b1;
            red       <= '0;
            green     <= '0;
            blue      <= '0;
        end else begin
            active_d  <= active;   // stage 1, aligns with sprite and text
            hsync_d   <= hsync;
            vsync_d   <= vsync;
            hsync_out <= hsync_d;  // stage 2
            vsync_out <= vsync_d;
            red       <= display_pixel[15:12];
            green     <= display_pixel[10:7];
            blue      <= display_pixel[4:1];
        end
    end

endmodule

// File: score_text.sv
module score_text #(
    parameter int TEXT_X = 500,
    parameter int TEXT_Y = 40
) (
    input  logic               clk,
    input  game_pkg::score_t   score,
    input  video_pkg::coord_t  x_pixel,
    input  video_pkg::coord_t  y_pixel,
    output video_pkg::pixel_t  text_pixel,
    output logic               text_area
);

    // two 8x8 glyphs, doubled, give a 32x16 box
    localparam int TEXT_W = 32;
    localparam int TEXT_H = 16;

    logic [3:0]        digit_tens;
    logic [3:0]        digit_ones;
    video_pkg::coord_t x_rel;
    video_pkg::coord_t y_rel;
    logic              in_text;
    logic [2:0]        font_row;
    logic [2:0]        font_col;
    logic [7:0]        font_data;

    // glyph rows packed top row first
    function automatic logic [7:0] glyph_row(logic [3:0] digit, logic [2:0] row);
        logic [63:0] glyph;
        case (digit)
            4'd0:    glyph = 64'h3C666E7666663C00;
            4'd1:    glyph = 64'h1838181818187E00;
            4'd2:    glyph = 64'h3C66060C30607E00;
            4'd3:    glyph = 64'h3C66061C06663C00;
            4'd4:    glyph = 64'h0C1C3C6C7E0C0C00;
            4'd5:    glyph = 64'h7E607C0606663C00;
            4'd6:    glyph = 64'h3C607C6666663C00;
            4'd7:    glyph = 64'h7E060C1830303000;
            4'd8:    glyph = 64'h3C66663C66663C00;
            4'd9:    glyph = 64'h3C66663E06063C00;
            default: glyph = '0;
        endcase
        return glyph[(7 - row) * 8 +: 8];
    endfunction

    assign digit_tens = 4'(score / 10);
    assign digit_ones = 4'(score % 10);

    assign x_rel   = x_pixel - video_pkg::coord_t'(TEXT_X);
    assign y_rel   = y_pixel - video_pkg::coord_t'(TEXT_Y);
    assign in_text = (x_pixel >= TEXT_X) && (x_pixel < TEXT_X + TEXT_W) &&
                     (y_pixel >= TEXT_Y) && (y_pixel < TEXT_Y + TEXT_H);

    // halve the offset for the 2x scale
    assign font_row  = y_rel[3:1];
    assign font_col  = x_rel[3:1];
    assign font_data = glyph_row(x_rel[4] ? digit_ones : digit_tens, font_row);

    always_ff @(posedge clk) begin
        text_pixel <= (in_text && font_data[7 - font_col]) ? 16'hFFFF : 16'h0000;
        text_area  <= in_text;
    end

endmodule

// File: ball_sprite_rom.sv
module ball_sprite_rom (
    input  logic               clk,
    input  video_pkg::coord_t  ball_x,
    input  video_pkg::coord_t  ball_y,
    input  video_pkg::coord_t  x_pixel,
    input  video_pkg::coord_t  y_pixel,
    output video_pkg::pixel_t  rom_pixel,
    output logic               hit_area
);

    video_pkg::coord_t  x_diff;
    video_pkg::coord_t  y_diff;
    video_pkg::offset_t x_offset;
    video_pkg::offset_t y_offset;
    logic               in_box;

    // round ball, radius 10 around (10,10)
    function automatic logic in_circle(video_pkg::offset_t dx, video_pkg::offset_t dy);
        int cx;
        int cy;
        cx = int'(dx) - 10;
        cy = int'(dy) - 10;
        return (cx * cx + cy * cy) < 100;
    endfunction

    assign x_diff   = x_pixel - ball_x;
    assign y_diff   = y_pixel - ball_y;
    assign x_offset = video_pkg::offset_t'(x_diff);
    assign y_offset = video_pkg::offset_t'(y_diff);

    // diff only meaningful once the coordinate is past the ball corner
    assign in_box = (x_pixel >= ball_x) && (y_pixel >= ball_y) &&
                    (x_diff < video_pkg::BALL_SIZE) && (y_diff < video_pkg::BALL_SIZE);

    always_ff @(posedge clk) begin
        rom_pixel <= in_circle(x_offset, y_offset) ? video_pkg::SPRITE_COLOUR : '0;
        hit_area  <= in_box;
    end

endmodule

// File: game_ctrl.sv
module game_ctrl #(
    parameter logic [3:0] HIT_LUMA = game_pkg::HIT_LUMA
) (
    input  logic                clk,
    input  logic                rst_n,
    // wishbone classic slave
    input  logic                cyc,
    input  logic                stb,
    input  logic                we,
    input  game_pkg::wb_addr_t  adr,
    input  game_pkg::wb_data_t  dat_w,
    output game_pkg::wb_data_t  dat_r,
    output logic                ack,
    // video side
    input  logic                frame_start,
    input  logic                active,
    input  logic                hit_area,
    input  video_pkg::pixel_t   camera_pixel,
    output video_pkg::coord_t   ball_x,
    output video_pkg::coord_t   ball_y,
    output game_pkg::score_t    score
);

    game_pkg::bus_state_t state;

    video_pkg::coord_t host_x;
    video_pkg::coord_t host_y;
    game_pkg::score_t  host_score;
    logic              hit_flag;
    logic              active_d;  // lines up with hit_area and camera_pixel
    logic              wr_ack;
    logic              status_rd;
    logic              hit_now;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= game_pkg::WB_IDLE;
        end else begin
            case (state)
                game_pkg::WB_IDLE: if (cyc && stb) state <= game_pkg::WB_ACK;
                default:           state <= game_pkg::WB_IDLE;  // one cycle ack
            endcase
        end
    end

    assign ack       = (state == game_pkg::WB_ACK);
    assign wr_ack    = ack && we;
    assign status_rd = ack && !we && (adr == game_pkg::REG_STATUS);
    assign hit_now   = active_d && hit_area && (camera_pixel[10:7] >= HIT_LUMA);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            host_x     <= '0;
            host_y     <= '0;
            host_score <= '0;
        end else if (wr_ack) begin
            case (adr)
                game_pkg::REG_BALL_X: host_x <= video_pkg::coord_t'(dat_w);
                game_pkg::REG_BALL_Y: host_y <= video_pkg::coord_t'(dat_w);
                game_pkg::REG_SCORE:
                    host_score <= (dat_w > 16'd99) ? 8'd99 : game_pkg::score_t'(dat_w);
                default: ;  // status is read only
            endcase
        end
    end

    // shadow copy, only at frame start so a frame never tears
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ball_x <= '0;
            ball_y <= '0;
            score  <= '0;
        end else if (frame_start) begin
            ball_x <= host_x;
            ball_y <= host_y;
            score  <= host_score;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active_d <= 1'b0;
            hit_flag <= 1'b0;
        end else begin
            active_d <= active;
            if (hit_now)
                hit_flag <= 1'b1;  // a new hit beats the clear
            else if (status_rd)
                hit_flag <= 1'b0;
        end
    end

    always_comb begin
        dat_r = '0;
        if (ack && !we) begin
            case (adr)
                game_pkg::REG_BALL_X: dat_r = game_pkg::wb_data_t'(host_x);
                game_pkg::REG_BALL_Y: dat_r = game_pkg::wb_data_t'(host_y);
                game_pkg::REG_SCORE:  dat_r = game_pkg::wb_data_t'(host_score);
                default:              dat_r = game_pkg::wb_data_t'(hit_flag);
            endcase
        end
    end

endmodule

// File: vga_timing.sv
module vga_timing #(
    parameter int H_ACTIVE = video_pkg::H_ACTIVE,
    parameter int H_FRONT  = video_pkg::H_FRONT,
    parameter int H_SYNC   = video_pkg::H_SYNC,
    parameter int H_BACK   = video_pkg::H_BACK,
    parameter int V_ACTIVE = video_pkg::V_ACTIVE,
    parameter int V_FRONT  = video_pkg::V_FRONT,
    parameter int V_SYNC   = video_pkg::V_SYNC,
    parameter int V_BACK   = video_pkg::V_BACK
) (
    input  logic               clk,
    input  logic               rst_n,
    output video_pkg::coord_t  x_pixel,
    output video_pkg::coord_t  y_pixel,
    output logic               active,
    output logic               hsync,
    output logic               vsync,
    output logic               frame_start
);

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    video_pkg::coord_t h_cnt;
    video_pkg::coord_t v_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_TOTAL - 1) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == V_TOTAL - 1) ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign x_pixel = h_cnt;
    assign y_pixel = v_cnt;
    assign active  = (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);

    // negative polarity pulses
    assign hsync = !((h_cnt >= H_ACTIVE + H_FRONT) && (h_cnt < H_ACTIVE + H_FRONT + H_SYNC));
    assign vsync = !((v_cnt >= V_ACTIVE + V_FRONT) && (v_cnt < V_ACTIVE + V_FRONT + V_SYNC));

    assign frame_start = (h_cnt == '0) && (v_cnt == '0);

endmodule

// File: game_pkg.sv
package game_pkg;

    typedef logic [1:0]  wb_addr_t;
    typedef logic [15:0] wb_data_t;
    typedef logic [7:0]  score_t;

    // host register map, word addresses
    localparam wb_addr_t REG_BALL_X = 2'd0;
    localparam wb_addr_t REG_BALL_Y = 2'd1;
    localparam wb_addr_t REG_SCORE  = 2'd2;
    localparam wb_addr_t REG_STATUS = 2'd3;  // bit 0 hit, clear on read

    typedef enum logic {
        WB_IDLE,
        WB_ACK
    } bus_state_t;

    // compared against the green channel of the camera pixel
    localparam logic [3:0] HIT_LUMA = 4'd12;

endpackage

// File: video_pkg.sv
package video_pkg;

    typedef logic [9:0]  coord_t;   // screen x or y
    typedef logic [15:0] pixel_t;   // rgb565
    typedef logic [3:0]  colour_t;  // one vga channel
    typedef logic [4:0]  offset_t;  // position inside the ball box

    // 640x480 @ 60 Hz, 25 MHz pixel clock
    localparam int H_ACTIVE = 640;
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BACK   = 48;

    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;

    localparam int BALL_SIZE = 20;

    localparam pixel_t SPRITE_COLOUR = 16'hFC00;  // orange

endpackage
